// File: tile_pkg.sv
`default_nettype none

package tile_pkg;

  // ---------------------------------------------------------------------------
  // element sizes and field widths
  // ---------------------------------------------------------------------------
  localparam int BYTES_A     = 1;   // activation
  localparam int BYTES_W     = 1;   // weight
  localparam int BYTES_P     = 2;   // psum / ofmap
  localparam int KERNEL_TAPS = 9;   // 3x3 kernel
  localparam int IDX_W       = 7;
  localparam int DIM_W       = 10;
  localparam int ADDR_W      = 32;

  typedef enum logic [1:0] {
    KIND_IFMAP,
    KIND_WEIGHT,
    KIND_BIAS,
    KIND_OFMAP
  } dma_kind_e;

  // ---------------------------------------------------------------------------
  // layer descriptor and derived geometry
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [IDX_W-1:0]  tile_r;        // ifmap rows per tile
    logic [IDX_W-1:0]  tile_d;        // input channels per tile
    logic [IDX_W-1:0]  tile_k;        // output channels per tile
    logic [IDX_W-1:0]  out_tile_r;    // ofmap rows per tile
    logic [IDX_W-1:0]  num_tiles_r;
    logic [IDX_W-1:0]  num_tiles_d;
    logic [IDX_W-1:0]  num_tiles_k;
    logic [DIM_W-1:0]  in_c;
    logic [DIM_W-1:0]  in_r;
    logic [DIM_W-1:0]  in_d;
    logic [DIM_W-1:0]  out_c;
    logic [DIM_W-1:0]  out_r;
    logic [ADDR_W-1:0] base_ifmap;
    logic [ADDR_W-1:0] base_weight;
    logic [ADDR_W-1:0] base_bias;
    logic [ADDR_W-1:0] base_ofmap;
    logic              bias_en;
  } tile_desc_t;

  typedef struct packed {
    logic [ADDR_W-1:0] ifmap_len;
    logic [ADDR_W-1:0] weight_len;
    logic [ADDR_W-1:0] bias_len;
    logic [ADDR_W-1:0] ofmap_len;
    logic [ADDR_W-1:0] ifmap_d_stride;
    logic [ADDR_W-1:0] ifmap_r_stride;
    logic [ADDR_W-1:0] weight_k_stride;
    logic [ADDR_W-1:0] weight_d_stride;
    logic [ADDR_W-1:0] bias_k_stride;
    logic [ADDR_W-1:0] ofmap_k_stride;
    logic [ADDR_W-1:0] ofmap_r_stride;
    logic [ADDR_W-1:0] base_ifmap;
    logic [ADDR_W-1:0] base_weight;
    logic [ADDR_W-1:0] base_bias;
    logic [ADDR_W-1:0] base_ofmap;
  } layer_geom_t;

  // ---------------------------------------------------------------------------
  // requests and commands
  // ---------------------------------------------------------------------------
  typedef struct packed {
    dma_kind_e        kind;
    logic [IDX_W-1:0] k_idx;
    logic [IDX_W-1:0] r_idx;
    logic [IDX_W-1:0] d_idx;
  } tile_req_t;

  typedef struct packed {
    logic              read;   // 1 = dram read
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] len;
  } dma_cmd_t;

  typedef struct packed {
    logic [IDX_W-1:0] tile_r;
    logic [IDX_W-1:0] tile_d;
    logic [IDX_W-1:0] tile_k;
    logic [IDX_W-1:0] out_tile_r;
    logic [IDX_W-1:0] k_idx;
    logic [IDX_W-1:0] r_idx;
    logic [IDX_W-1:0] d_idx;
    logic             bias_en;
  } pass_info_t;

endpackage

`default_nettype wire

// File: desc_loader.sv
`timescale 1ns/1ns
`default_nettype none

module desc_loader
  import tile_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        desc_vld_i,
  input  wire tile_desc_t  desc_i,
  input  wire logic        layer_done_i,
  output logic             busy_o,
  output logic             start_o,
  output tile_desc_t       desc_o,
  output layer_geom_t      geom_o
);

  logic        busy_q;
  logic        pend_q;      // descriptor captured, geometry due next edge
  logic        capture;
  tile_desc_t  desc_q;
  layer_geom_t geom_q;

  // busy drops together with the layer done pulse
  assign busy_o  = busy_q & ~layer_done_i;
  assign capture = desc_vld_i & ~busy_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      pend_q  <= 1'b0;
      start_o <= 1'b0;
    end else begin
      pend_q  <= capture;
      start_o <= pend_q;    // start lines up with geom
      if (capture)
        busy_q <= 1'b1;
      else if (layer_done_i)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture)
      desc_q <= desc_i;
  end

  // ---------------------------------------------------------------------------
  // per-layer lengths and strides, all in bytes, mod 2^32
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pend_q) begin
      geom_q.ifmap_len       <= ADDR_W'(desc_q.tile_d) * ADDR_W'(desc_q.tile_r) *
                                ADDR_W'(desc_q.in_c) * ADDR_W'(BYTES_A);
      geom_q.weight_len      <= ADDR_W'(desc_q.tile_k) * ADDR_W'(desc_q.tile_d) *
                                ADDR_W'(KERNEL_TAPS) * ADDR_W'(BYTES_W);
      geom_q.bias_len        <= ADDR_W'(desc_q.tile_k) * ADDR_W'(BYTES_P);
      geom_q.ofmap_len       <= ADDR_W'(desc_q.tile_k) * ADDR_W'(desc_q.out_tile_r) *
                                ADDR_W'(desc_q.out_c) * ADDR_W'(BYTES_P);
      geom_q.ifmap_d_stride  <= ADDR_W'(desc_q.tile_d) * ADDR_W'(desc_q.in_r) *
                                ADDR_W'(desc_q.in_c) * ADDR_W'(BYTES_A);
      geom_q.ifmap_r_stride  <= ADDR_W'(desc_q.out_tile_r) * ADDR_W'(desc_q.in_c) *
                                ADDR_W'(BYTES_A);
      geom_q.weight_k_stride <= ADDR_W'(desc_q.tile_k) * ADDR_W'(desc_q.in_d) *
                                ADDR_W'(KERNEL_TAPS) * ADDR_W'(BYTES_W);
      geom_q.weight_d_stride <= ADDR_W'(desc_q.tile_d) * ADDR_W'(KERNEL_TAPS) *
                                ADDR_W'(BYTES_W);
      geom_q.bias_k_stride   <= ADDR_W'(desc_q.tile_k) * ADDR_W'(BYTES_P);
      geom_q.ofmap_k_stride  <= ADDR_W'(desc_q.tile_k) * ADDR_W'(desc_q.out_r) *
                                ADDR_W'(desc_q.out_c) * ADDR_W'(BYTES_P);
      geom_q.ofmap_r_stride  <= ADDR_W'(desc_q.out_tile_r) * ADDR_W'(desc_q.out_c) *
                                ADDR_W'(BYTES_P);
      geom_q.base_ifmap      <= desc_q.base_ifmap;
      geom_q.base_weight     <= desc_q.base_weight;
      geom_q.base_bias       <= desc_q.base_bias;
      geom_q.base_ofmap      <= desc_q.base_ofmap;
    end
  end

  assign desc_o = desc_q;
  assign geom_o = geom_q;

endmodule

`default_nettype wire

// File: tile_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module tile_scheduler
  import tile_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       start_i,
  input  wire tile_desc_t desc_i,
  input  wire logic       dma_done_i,
  input  wire logic       pass_done_i,
  output logic            req_vld_o,
  output tile_req_t       req_o,
  output logic            pass_vld_o,
  output pass_info_t      pass_o,
  output logic            layer_done_o
);

  typedef enum logic [2:0] {
    IDLE,
    LOAD_IFMAP,
    LOAD_WEIGHT,
    LOAD_BIAS,
    RUN_PASS,
    STORE_OFMAP,
    NEXT_TILE
  } state_e;

  state_e           state_q, state_d;
  logic             issued_q;     // command of current state already sent
  logic [IDX_W-1:0] k_idx, r_idx, d_idx;
  logic             last_d, last_r, last_k;
  logic             is_dma_st;
  logic             step;         // current state finished

  // a count of zero behaves like one tile
  assign last_d = ({1'b0, d_idx} + 1'b1) >= {1'b0, desc_i.num_tiles_d};
  assign last_r = ({1'b0, r_idx} + 1'b1) >= {1'b0, desc_i.num_tiles_r};
  assign last_k = ({1'b0, k_idx} + 1'b1) >= {1'b0, desc_i.num_tiles_k};

  assign is_dma_st = (state_q == LOAD_IFMAP) || (state_q == LOAD_WEIGHT) ||
                     (state_q == LOAD_BIAS)  || (state_q == STORE_OFMAP);
  assign step      = issued_q & ((is_dma_st & dma_done_i) |
                                 ((state_q == RUN_PASS) & pass_done_i));

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (start_i) state_d = LOAD_IFMAP;
      LOAD_IFMAP:  if (step) state_d = LOAD_WEIGHT;
      LOAD_WEIGHT: if (step) state_d = desc_i.bias_en ? LOAD_BIAS : RUN_PASS;
      LOAD_BIAS:   if (step) state_d = RUN_PASS;
      RUN_PASS:    if (step) state_d = last_d ? STORE_OFMAP : NEXT_TILE;
      STORE_OFMAP: if (step) state_d = (last_r && last_k) ? IDLE : NEXT_TILE;
      NEXT_TILE:   state_d = LOAD_IFMAP;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      issued_q     <= 1'b0;
      layer_done_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      layer_done_o <= (state_q == STORE_OFMAP) && step && last_r && last_k;
      if (state_d != state_q)
        issued_q <= 1'b0;           // fresh state, nothing sent yet
      else if (req_vld_o || pass_vld_o)
        issued_q <= 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // loop counters, d wraps first, then r, then k
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      k_idx <= '0;
      r_idx <= '0;
      d_idx <= '0;
    end else if (state_q == IDLE && start_i) begin
      k_idx <= '0;
      r_idx <= '0;
      d_idx <= '0;
    end else if (state_q == NEXT_TILE) begin
      if (!last_d) begin
        d_idx <= d_idx + 1'b1;
      end else begin
        d_idx <= '0;
        if (!last_r) begin
          r_idx <= r_idx + 1'b1;
        end else begin
          r_idx <= '0;
          k_idx <= k_idx + 1'b1;
        end
      end
    end
  end

  // one request per state, sent in its first cycle
  assign req_vld_o  = is_dma_st & ~issued_q;
  assign pass_vld_o = (state_q == RUN_PASS) & ~issued_q;

  always_comb begin
    case (state_q)
      LOAD_WEIGHT: req_o.kind = KIND_WEIGHT;
      LOAD_BIAS:   req_o.kind = KIND_BIAS;
      STORE_OFMAP: req_o.kind = KIND_OFMAP;
      default:     req_o.kind = KIND_IFMAP;
    endcase
  end

  assign req_o.k_idx = k_idx;
  assign req_o.r_idx = r_idx;
  assign req_o.d_idx = d_idx;

  assign pass_o.tile_r     = desc_i.tile_r;
  assign pass_o.tile_d     = desc_i.tile_d;
  assign pass_o.tile_k     = desc_i.tile_k;
  assign pass_o.out_tile_r = desc_i.out_tile_r;
  assign pass_o.k_idx      = k_idx;
  assign pass_o.r_idx      = r_idx;
  assign pass_o.d_idx      = d_idx;
  assign pass_o.bias_en    = desc_i.bias_en;

endmodule

`default_nettype wire

// File: tile_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tile_addr_gen
  import tile_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        req_vld_i,
  input  wire tile_req_t   req_i,
  input  wire layer_geom_t geom_i,
  output logic             cmd_vld_o,
  output dma_cmd_t         cmd_o
);

  logic [ADDR_W-1:0] idx_a, idx_b;       // index operands, zero extended
  logic [ADDR_W-1:0] stride_a, stride_b;
  logic              vld1_q;
  dma_kind_e         kind1_q;
  logic [ADDR_W-1:0] prod_a_q, prod_b_q;
  logic [ADDR_W-1:0] base1, len1;

  // ---------------------------------------------------------------------------
  // stage 1: pick strides by kind, form index products
  // ---------------------------------------------------------------------------
  always_comb begin
    idx_a    = ADDR_W'(req_i.k_idx);
    idx_b    = ADDR_W'(req_i.r_idx);
    stride_a = '0;
    stride_b = '0;
    case (req_i.kind)
      KIND_IFMAP: begin
        idx_a    = ADDR_W'(req_i.d_idx);
        stride_a = geom_i.ifmap_d_stride;
        stride_b = geom_i.ifmap_r_stride;
      end
      KIND_WEIGHT: begin
        idx_b    = ADDR_W'(req_i.d_idx);
        stride_a = geom_i.weight_k_stride;
        stride_b = geom_i.weight_d_stride;
      end
      KIND_BIAS: begin
        stride_a = geom_i.bias_k_stride;   // no second term
      end
      default: begin
        stride_a = geom_i.ofmap_k_stride;
        stride_b = geom_i.ofmap_r_stride;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    kind1_q  <= req_i.kind;
    prod_a_q <= idx_a * stride_a;
    prod_b_q <= idx_b * stride_b;
  end

  // ---------------------------------------------------------------------------
  // stage 2: add base, attach length and direction
  // ---------------------------------------------------------------------------
  always_comb begin
    case (kind1_q)
      KIND_IFMAP:  begin base1 = geom_i.base_ifmap;  len1 = geom_i.ifmap_len;  end
      KIND_WEIGHT: begin base1 = geom_i.base_weight; len1 = geom_i.weight_len; end
      KIND_BIAS:   begin base1 = geom_i.base_bias;   len1 = geom_i.bias_len;   end
      default:     begin base1 = geom_i.base_ofmap;  len1 = geom_i.ofmap_len;  end
    endcase
  end

  always_ff @(posedge clk) begin
    cmd_o.read <= (kind1_q != KIND_OFMAP);
    cmd_o.addr <= base1 + prod_a_q + prod_b_q;
    cmd_o.len  <= len1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld1_q    <= 1'b0;
      cmd_vld_o <= 1'b0;
    end else begin
      vld1_q    <= req_vld_i;
      cmd_vld_o <= vld1_q;
    end
  end

endmodule

`default_nettype wire

// File: cmd_issuer.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_issuer
  import tile_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       cmd_vld_i,
  input  wire dma_cmd_t   cmd_i,
  input  wire logic       pass_vld_i,
  input  wire pass_info_t pass_i,
  input  wire logic       dma_done_i,
  input  wire logic       pass_done_i,
  output logic            dma_req_vld_o,
  output dma_cmd_t        dma_cmd_o,
  output logic            pass_info_vld_o,
  output pass_info_t      pass_info_o,
  output logic            dma_done_o,
  output logic            pass_done_o
);

  logic dma_busy;   // a dma command is out
  logic pass_busy;  // a pass is running

  // ---------------------------------------------------------------------------
  // output registers, payload held until the next command
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cmd_vld_i)
      dma_cmd_o <= cmd_i;
    if (pass_vld_i)
      pass_info_o <= pass_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dma_req_vld_o   <= 1'b0;
      pass_info_vld_o <= 1'b0;
    end else begin
      dma_req_vld_o   <= cmd_vld_i;
      pass_info_vld_o <= pass_vld_i;
    end
  end

  // ---------------------------------------------------------------------------
  // outstanding flags, stray done pulses are dropped
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dma_busy <= 1'b0;
    end else if (cmd_vld_i) begin
      dma_busy <= 1'b1;
    end else if (dma_done_o) begin
      dma_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_busy <= 1'b0;
    end else if (pass_vld_i) begin
      pass_busy <= 1'b1;
    end else if (pass_done_o) begin
      pass_busy <= 1'b0;
    end
  end

  assign dma_done_o  = dma_done_i & dma_busy;
  assign pass_done_o = pass_done_i & pass_busy;

endmodule

`default_nettype wire

// File: tile_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module tile_ctrl_top
  import tile_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // descriptor
  input  wire logic       desc_vld_i,
  input  wire tile_desc_t desc_i,
  // dma port
  output logic            dma_req_vld_o,
  output dma_cmd_t        dma_cmd_o,
  input  wire logic       dma_done_i,
  // pass port
  output logic            pass_info_vld_o,
  output pass_info_t      pass_info_o,
  input  wire logic       pass_done_i,
  // status
  output logic            busy_o,
  output logic            layer_done_o
);

  logic        start;
  tile_desc_t  desc;
  layer_geom_t geom;
  logic        req_vld;
  tile_req_t   req;
  logic        cmd_vld;
  dma_cmd_t    cmd;
  logic        pass_vld;
  pass_info_t  pass;
  logic        dma_done;
  logic        pass_done;

  desc_loader u_desc_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .desc_vld_i   (desc_vld_i),
    .desc_i       (desc_i),
    .layer_done_i (layer_done_o),
    .busy_o       (busy_o),
    .start_o      (start),
    .desc_o       (desc),
    .geom_o       (geom)
  );

  tile_scheduler u_tile_scheduler (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .desc_i       (desc),
    .dma_done_i   (dma_done),
    .pass_done_i  (pass_done),
    .req_vld_o    (req_vld),
    .req_o        (req),
    .pass_vld_o   (pass_vld),
    .pass_o       (pass),
    .layer_done_o (layer_done_o)
  );

  tile_addr_gen u_tile_addr_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_vld_i (req_vld),
    .req_i     (req),
    .geom_i    (geom),
    .cmd_vld_o (cmd_vld),
    .cmd_o     (cmd)
  );

  cmd_issuer u_cmd_issuer (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_vld_i       (cmd_vld),
    .cmd_i           (cmd),
    .pass_vld_i      (pass_vld),
    .pass_i          (pass),
    .dma_done_i      (dma_done_i),
    .pass_done_i     (pass_done_i),
    .dma_req_vld_o   (dma_req_vld_o),
    .dma_cmd_o       (dma_cmd_o),
    .pass_info_vld_o (pass_info_vld_o),
    .pass_info_o     (pass_info_o),
    .dma_done_o      (dma_done),
    .pass_done_o     (pass_done)
  );

endmodule

`default_nettype wire

// File: tile_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tile_ctrl_checker
  import tile_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       test_start_i,
  input  wire logic       test_end_i,
  input  wire logic [3:0] test_idx_i,
  input  wire tile_desc_t test_desc_i,
  input  wire logic       dma_req_vld_i,
  input  wire dma_cmd_t   dma_cmd_i,
  input  wire logic       pass_info_vld_i,
  input  wire pass_info_t pass_info_i,
  input  wire logic       layer_done_i,
  input  wire logic       busy_i,
  output int              err_cnt_o,
  output int              tests_o,
  output int              failed_o
);

  typedef struct packed {
    logic       is_pass;
    dma_cmd_t   cmd;
    pass_info_t pass;
  } exp_evt_t;

  tile_desc_t desc_q;
  string      name;
  logic       active   = 1'b0;
  logic       layer_on = 1'b0;   // descriptor taken, layer done not yet seen
  logic       busy_exp;
  int         n_evt    = 0;
  int         n_total  = 0;
  int         n_done   = 0;
  int         t_err    = 0;
  int         err_cnt  = 0;
  int         tests    = 0;
  int         failed   = 0;

  assign err_cnt_o = err_cnt;
  assign tests_o   = tests;
  assign failed_o  = failed;

  function automatic string test_name(input int idx);
    case (idx)
      0:       return "single_tile";
      1:       return "multi_bias";
      2:       return "multi_nobias";
      3:       return "busy_ignore";
      default: return $sformatf("random_%0d", idx - 4);
    endcase
  endfunction

  function automatic int event_total(input tile_desc_t d);
    int per_d;
    per_d = d.bias_en ? 4 : 3;   // ifmap, weight, [bias], pass
    return int'(d.num_tiles_k) * int'(d.num_tiles_r) * (int'(d.num_tiles_d) * per_d + 1);
  endfunction

  // --------------------------------------------------------------------------
  // reference model for event n of a layer in K -> R -> D order
  // --------------------------------------------------------------------------
  function automatic exp_evt_t ref_event(input tile_desc_t d, input int n);
    exp_evt_t    e;
    int          per_d, per_kr, kr, rem, slot;
    logic [31:0] k, r, dd;
    logic [31:0] t_r, t_d, t_k, t_or, c_in, r_in, d_in, c_out, r_out;
    per_d  = d.bias_en ? 4 : 3;
    per_kr = int'(d.num_tiles_d) * per_d + 1;  // plus the ofmap write
    kr     = n / per_kr;
    rem    = n % per_kr;
    slot   = rem % per_d;
    k      = 32'(kr / int'(d.num_tiles_r));
    r      = 32'(kr % int'(d.num_tiles_r));
    dd     = 32'(rem / per_d);
    t_r    = 32'(d.tile_r);
    t_d    = 32'(d.tile_d);
    t_k    = 32'(d.tile_k);
    t_or   = 32'(d.out_tile_r);
    c_in   = 32'(d.in_c);
    r_in   = 32'(d.in_r);
    d_in   = 32'(d.in_d);
    c_out  = 32'(d.out_c);
    r_out  = 32'(d.out_r);
    e = '0;
    e.cmd.read = 1'b1;
    e.pass.tile_r     = d.tile_r;
    e.pass.tile_d     = d.tile_d;
    e.pass.tile_k     = d.tile_k;
    e.pass.out_tile_r = d.out_tile_r;
    e.pass.k_idx      = k[IDX_W-1:0];
    e.pass.r_idx      = r[IDX_W-1:0];
    e.pass.d_idx      = dd[IDX_W-1:0];
    e.pass.bias_en    = d.bias_en;
    if (rem == per_kr - 1) begin       // write back
      e.cmd.read = 1'b0;
      e.cmd.len  = t_k * t_or * c_out * BYTES_P;
      e.cmd.addr = d.base_ofmap + k * t_k * r_out * c_out * BYTES_P +
                   r * t_or * c_out * BYTES_P;
    end else if (slot == 0) begin
      e.cmd.len  = t_d * t_r * c_in * BYTES_A;
      e.cmd.addr = d.base_ifmap + dd * t_d * r_in * c_in * BYTES_A +
                   r * t_or * c_in * BYTES_A;
    end else if (slot == 1) begin
      e.cmd.len  = t_k * t_d * KERNEL_TAPS * BYTES_W;
      e.cmd.addr = d.base_weight + k * t_k * d_in * KERNEL_TAPS * BYTES_W +
                   dd * t_d * KERNEL_TAPS * BYTES_W;
    end else if (slot == 2 && d.bias_en) begin
      e.cmd.len  = t_k * BYTES_P;
      e.cmd.addr = d.base_bias + k * t_k * BYTES_P;
    end else begin
      e.is_pass = 1'b1;
    end
    return e;
  endfunction

  task automatic check_dma();
    exp_evt_t e;
    string    exp_s, act_s;
    if (!active) begin
      $display("dma command seen while no test was running");
      err_cnt++;
    end else if (n_evt >= n_total) begin
      $display("%s: dma command after the last expected event", name);
      t_err++;
    end else begin
      e = ref_event(desc_q, n_evt);
      if (e.is_pass) begin
        $display("%s: dma command at event %0d where a pass was expected", name, n_evt);
        t_err++;
      end else if (dma_cmd_i !== e.cmd) begin
        exp_s = $sformatf("read=%0b addr=%h len=%h", e.cmd.read, e.cmd.addr, e.cmd.len);
        act_s = $sformatf("read=%0b addr=%h len=%h", dma_cmd_i.read, dma_cmd_i.addr,
                          dma_cmd_i.len);
        $display("error %s event %0d: expected %s, actual %s", name, n_evt, exp_s, act_s);
        t_err++;
      end
    end
    n_evt++;
  endtask

  task automatic check_pass();
    exp_evt_t e;
    if (!active) begin
      $display("pass started while no test was running");
      err_cnt++;
    end else if (n_evt >= n_total) begin
      $display("%s: pass after the last expected event", name);
      t_err++;
    end else begin
      e = ref_event(desc_q, n_evt);
      if (!e.is_pass) begin
        $display("%s: pass at event %0d where a dma command was expected", name, n_evt);
        t_err++;
      end else if (pass_info_i !== e.pass) begin
        $display("error %s event %0d: expected pass %h, actual pass %h",
                 name, n_evt, e.pass, pass_info_i);
        t_err++;
      end
    end
    n_evt++;
  endtask

  task automatic finish_test();
    if (n_done != 1) begin
      $display("%s: layer done pulsed %0d times instead of once", name, n_done);
      t_err++;
    end
    if (n_evt != n_total) begin
      $display("error %s event count: expected %0d, actual %0d", name, n_total, n_evt);
      t_err++;
    end
    $display("test %-12s %4d events  %s", name, n_evt, (t_err == 0) ? "ok" : "failed");
    tests++;
    if (t_err != 0)
      failed++;
    err_cnt += t_err;
    active = 1'b0;
  endtask

  // dut outputs are registered and settled before each edge
  always @(posedge clk) begin
    if (rst_n) begin
      busy_exp = layer_on;
      if (layer_done_i)
        busy_exp = 1'b0;             // busy falls in the layer done cycle
      if (busy_i !== busy_exp) begin
        if (active) begin
          $display("error %s busy: expected %0b, actual %0b", name, busy_exp, busy_i);
          t_err++;
        end else begin
          $display("busy was %0b while no layer was running", busy_i);
          err_cnt++;
        end
      end
      if (test_start_i) begin
        desc_q   = test_desc_i;
        name     = test_name(int'(test_idx_i));
        n_total  = event_total(test_desc_i);
        n_evt    = 0;
        n_done   = 0;
        t_err    = 0;
        active   = 1'b1;
        layer_on = 1'b1;
      end
      if (dma_req_vld_i)
        check_dma();
      if (pass_info_vld_i)
        check_pass();
      if (layer_done_i) begin
        layer_on = 1'b0;
        if (!active) begin
          $display("layer done pulsed while no test was running");
          err_cnt++;
        end else begin
          n_done++;
          if (n_evt != n_total) begin
            $display("error %s layer done: expected after %0d events, actual after %0d",
                     name, n_total, n_evt);
            t_err++;
          end
        end
      end
      if (test_end_i && active)
        finish_test();
    end
  end

endmodule

`default_nettype wire

// File: tb_tile_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tile_ctrl
  import tile_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int MAX_DELAY  = 7;
  localparam int N_TESTS    = 8;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       desc_vld;
  tile_desc_t desc;
  logic       dma_req_vld;
  dma_cmd_t   dma_cmd;
  logic       dma_done;
  logic       pass_info_vld;
  pass_info_t pass_info;
  logic       pass_done;
  logic       busy;
  logic       layer_done;

  logic       test_start;
  logic       test_end;
  logic [3:0] test_idx;
  tile_desc_t test_desc;
  int         err_cnt, tests, failed;

  integer     seed = 53;
  int         limit_cycles = 0;
  tile_desc_t descs [N_TESTS];

  always #(CLK_PERIOD / 2) clk = ~clk;

  tile_ctrl_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .desc_vld_i      (desc_vld),
    .desc_i          (desc),
    .dma_req_vld_o   (dma_req_vld),
    .dma_cmd_o       (dma_cmd),
    .dma_done_i      (dma_done),
    .pass_info_vld_o (pass_info_vld),
    .pass_info_o     (pass_info),
    .pass_done_i     (pass_done),
    .busy_o          (busy),
    .layer_done_o    (layer_done)
  );

  tile_ctrl_checker chk0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .test_start_i    (test_start),
    .test_end_i      (test_end),
    .test_idx_i      (test_idx),
    .test_desc_i     (test_desc),
    .dma_req_vld_i   (dma_req_vld),
    .dma_cmd_i       (dma_cmd),
    .pass_info_vld_i (pass_info_vld),
    .pass_info_i     (pass_info),
    .layer_done_i    (layer_done),
    .busy_i          (busy),
    .err_cnt_o       (err_cnt),
    .tests_o         (tests),
    .failed_o        (failed)
  );

  function automatic int count_layer_events(input tile_desc_t d);
    return int'(d.num_tiles_k) * int'(d.num_tiles_r) *
           (int'(d.num_tiles_d) * (d.bias_en ? 4 : 3) + 1);
  endfunction

  // consistent geometry around the given tiling
  function automatic tile_desc_t shape(input int tr, input int td, input int tk, input int otr,
                                       input int nr, input int nd, input int nk,
                                       input logic bias);
    tile_desc_t d;
    d             = '0;
    d.tile_r      = IDX_W'(tr);
    d.tile_d      = IDX_W'(td);
    d.tile_k      = IDX_W'(tk);
    d.out_tile_r  = IDX_W'(otr);
    d.num_tiles_r = IDX_W'(nr);
    d.num_tiles_d = IDX_W'(nd);
    d.num_tiles_k = IDX_W'(nk);
    d.in_c        = DIM_W'(16);
    d.in_r        = DIM_W'(otr * nr + 2);   // 3x3 halo
    d.in_d        = DIM_W'(td * nd);
    d.out_c       = DIM_W'(14);
    d.out_r       = DIM_W'(otr * nr);
    d.base_ifmap  = 32'h1000_0000;
    d.base_weight = 32'h2000_0400;
    d.base_bias   = 32'h3000_0080;
    d.base_ofmap  = 32'h4000_1000;
    d.bias_en     = bias;
    return d;
  endfunction

  task automatic random_desc(output tile_desc_t d);
    d.tile_r      = IDX_W'(1 + {$random(seed)} % 8);
    d.tile_d      = IDX_W'(1 + {$random(seed)} % 8);
    d.tile_k      = IDX_W'(1 + {$random(seed)} % 8);
    d.out_tile_r  = IDX_W'(1 + {$random(seed)} % 8);
    d.num_tiles_r = IDX_W'(1 + {$random(seed)} % 3);
    d.num_tiles_d = IDX_W'(1 + {$random(seed)} % 3);
    d.num_tiles_k = IDX_W'(1 + {$random(seed)} % 3);
    d.in_c        = DIM_W'({$random(seed)});
    d.in_r        = DIM_W'({$random(seed)});
    d.in_d        = DIM_W'({$random(seed)});
    d.out_c       = DIM_W'({$random(seed)});
    d.out_r       = DIM_W'({$random(seed)});
    d.base_ifmap  = $random(seed);
    d.base_weight = $random(seed);
    d.base_bias   = $random(seed);
    d.base_ofmap  = $random(seed);
    d.bias_en     = 1'($random(seed));
  endtask

  task automatic build_tests();
    int total;
    descs[0] = shape(6, 4, 8, 4, 1, 1, 1, 1'b0);
    descs[1] = shape(6, 4, 8, 4, 2, 3, 2, 1'b1);
    descs[2] = shape(6, 4, 8, 4, 2, 3, 2, 1'b0);
    descs[3] = shape(5, 2, 4, 3, 2, 2, 1, 1'b1);
    for (int i = 4; i < N_TESTS; i++)
      random_desc(descs[i]);
    total = 0;
    for (int i = 0; i < N_TESTS; i++)
      total += count_layer_events(descs[i]);
    // per event pipeline and handshake turnaround plus the worst responder delay
    limit_cycles = 2 * (total * (MAX_DELAY + 8) + N_TESTS * 40) + 100;
  endtask

  // --------------------------------------------------------------------------
  // one layer with an optional second descriptor strobed while busy
  // --------------------------------------------------------------------------
  task automatic run_layer(input int idx, input tile_desc_t d, input logic extra);
    tile_desc_t other;
    test_idx   = 4'(idx);
    test_desc  = d;
    test_start = 1'b1;
    desc       = d;
    desc_vld   = 1'b1;
    @(negedge clk);
    test_start = 1'b0;
    desc_vld   = 1'b0;
    if (extra) begin
      while (!busy)
        @(negedge clk);
      other             = d;
      other.base_ifmap  = ~d.base_ifmap;
      other.num_tiles_k = d.num_tiles_k + 1'b1;
      other.bias_en     = ~d.bias_en;
      desc              = other;
      desc_vld          = 1'b1;
      @(negedge clk);
      desc_vld = 1'b0;
    end
    while (!layer_done)
      @(negedge clk);
    repeat (8) @(negedge clk);   // room for any stray command
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  // dma engine model
  initial begin : dma_responder
    int delay;
    forever begin
      @(negedge clk);
      if (dma_req_vld) begin
        delay = {$random(seed)} % (MAX_DELAY + 1);
        repeat (delay) @(negedge clk);
        dma_done = 1'b1;
        @(negedge clk);
        dma_done = 1'b0;
      end
    end
  end

  // compute array model
  initial begin : pass_responder
    int delay;
    forever begin
      @(negedge clk);
      if (pass_info_vld) begin
        delay = {$random(seed)} % (MAX_DELAY + 1);
        repeat (delay) @(negedge clk);
        pass_done = 1'b1;
        @(negedge clk);
        pass_done = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    rst_n      = 1'b0;
    desc_vld   = 1'b0;
    desc       = '0;
    dma_done   = 1'b0;
    pass_done  = 1'b0;
    test_start = 1'b0;
    test_end   = 1'b0;
    test_idx   = '0;
    test_desc  = '0;
    build_tests();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int i = 0; i < N_TESTS; i++)
      run_layer(i, descs[i], i == 3);
    repeat (2) @(negedge clk);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, err_cnt);
    if (err_cnt == 0 && failed == 0 && tests == N_TESTS) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
tile_pkg.sv
desc_loader.sv
tile_scheduler.sv
tile_addr_gen.sv
cmd_issuer.sv
tile_ctrl_top.sv
tile_ctrl_checker.sv
tb_tile_ctrl.sv

// File: Makefile
TOP := tb_tile_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" sim.log; then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
